//--- tests/fusion_patterns.txt
// columns: mode en x y product sum, all hex, one row per cycle
// product is checked one cycle after the row is driven, sum two cycles after
// 8-bit mode, first row dropped on the mode change
2 1 80 80 4000000000000000 0
2 1 80 80 4000000000000000 04000000000000000000000000000000
2 1 FF 7F FF81000000000000 03F81000000000000000000000000000
2 0 12 34 03A8000000000000 03F81000000000000000000000000000
2 1 00 A5 0 03F81000000000000000000000000000
2 1 7F 7F 3F01000000000000 07E82000000000000000000000000000
2 1 80 7F C080000000000000 03F02000000000000000000000000000
// 4-bit mode, lanes hh hl lh ll
1 1 88 88 4040404000000000 0
1 1 88 88 4040404000000000 04004004004000000000000000000000
1 1 7F 87 C83108F900000000 00807104803900000000000000000000
1 0 11 22 0202020200000000 00807104803900000000000000000000
1 1 3C D5 F70F0CEC00000000 FFF08005402500000000000000000000
1 1 80 08 0040000000000000 FFF0C005402500000000000000000000
// invalid mode
3 1 55 55 0 0
3 1 FF FF 0 0
// 2-bit mode, sixteen crumb lanes
0 1 AA AA 4444444444444444 0
0 1 AA AA 4444444444444444 04040404040404040404040404040404
0 1 E4 1B 0F0E21420100EF00 04030402060508060405040402030404
0 0 FF FF 1111111111111111 04030402060508060405040402030404
0 1 1B E4 00FE00102412E0F0 04030300060509060609050600030304
0 1 55 AA EEEEEEEEEEEEEEEE 020101FE0403070404070304FE010102
0 1 FF 55 FFFFFFFFFFFFFFFF 010000FD0302060303060203FD000001
// back to 8-bit mode
2 1 FF FF 0001000000000000 0
2 1 FF 80 0080000000000000 00080000000000000000000000000000

//--- sim.f
rtl/fusion_pkg.sv
rtl/bitbrick.sv
rtl/sign_ctrl.sv
rtl/fusion_block.sv
rtl/fusion_array.sv
rtl/product_stage.sv
rtl/lane_accumulator.sv
rtl/fusion_mac.sv
tests/tb_fusion_mac.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fusion_mac
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  := sim.f
SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Simulation completed successfully

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when the file list or a source is newer than the binary
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_fusion_mac.sv
`timescale 1ns/1ps

module tb_fusion_mac;

    import fusion_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 5;
    localparam int    MAX_ROWS     = 64;
    // words per row: mode, en, x, y, product, sum
    localparam int    ROW_WORDS    = 6;
    localparam string PATTERN_FILE = "tests/fusion_patterns.txt";

    logic     clk;
    logic     nrst;
    operand_t x;
    operand_t y;
    mode_t    mode;
    logic     en;
    product_t product;
    sum_t     sum;

    // raw pattern words, one row is ROW_WORDS consecutive entries
    logic [127:0] pattern_mem [ROW_WORDS*MAX_ROWS];
    int           num_rows;
    int           prod_errors;
    int           sum_errors;

    fusion_mac fusion_mac_i (
        .clk     (clk),
        .nrst    (nrst),
        .x       (x),
        .y       (y),
        .mode    (mode),
        .en      (en),
        .product (product),
        .sum     (sum)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // pattern row fields
    ////////////////////////////////////////

    function automatic mode_t mode_of(input int r);
        return mode_t'(pattern_mem[ROW_WORDS*r][3:0]);
    endfunction

    function automatic logic en_of(input int r);
        return pattern_mem[ROW_WORDS*r+1][0];
    endfunction

    function automatic operand_t x_of(input int r);
        return pattern_mem[ROW_WORDS*r+2][7:0];
    endfunction

    function automatic operand_t y_of(input int r);
        return pattern_mem[ROW_WORDS*r+3][7:0];
    endfunction

    function automatic product_t expected_product(input int r);
        return pattern_mem[ROW_WORDS*r+4][63:0];
    endfunction

    function automatic sum_t expected_sum(input int r);
        return pattern_mem[ROW_WORDS*r+5];
    endfunction

    task automatic load_patterns();
        int fd;
        int rows;
        rows = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("pattern file %s could not be opened", PATTERN_FILE);
        end else begin
            $fclose(fd);
            // words not read from the file keep a fill that no en field holds
            for (int a = 0; a < ROW_WORDS*MAX_ROWS; a++) begin
                pattern_mem[a] = ~128'(a);
            end
            $readmemh(PATTERN_FILE, pattern_mem);
            // a row counts while its en word is 0 or 1
            while (rows < MAX_ROWS && pattern_mem[ROW_WORDS*rows+1] <= 128'd1) begin
                rows++;
            end
            if (rows == 0) begin
                $display("pattern file %s holds no rows", PATTERN_FILE);
            end
        end
        // count is published once, so the watchdog only ever sees the final value
        num_rows = rows;
    endtask

    ////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////

    task automatic apply_reset();
        nrst <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
    endtask

    task automatic drive_row(input int r);
        mode <= mode_of(r);
        en   <= en_of(r);
        x    <= x_of(r);
        y    <= y_of(r);
    endtask

    task automatic check_product(input int r);
        if (product !== expected_product(r)) begin
            $display("[ERROR] %0t: row %0d product %h, expected %h",
                     $time, r, product, expected_product(r));
            prod_errors++;
        end
    endtask

    task automatic check_sum(input int r);
        if (sum !== expected_sum(r)) begin
            $display("[ERROR] %0t: row %0d sum %h, expected %h",
                     $time, r, sum, expected_sum(r));
            sum_errors++;
        end
    endtask

    // row n enters the product register one edge after it is driven
    // and reaches the sum one edge after that
    task automatic run_patterns();
        for (int n = 0; n < num_rows + 2; n++) begin
            @(posedge clk);
            if (n < num_rows) begin
                drive_row(n);
            end else begin
                en <= 1'b0;
            end
            // registered outputs are settled by the falling edge
            @(negedge clk);
            if (n >= 1 && n <= num_rows) begin
                check_product(n - 1);
            end
            if (n >= 2) begin
                check_sum(n - 2);
            end
        end
    endtask

    task automatic report_counts();
        $display("rows %0d, product errors %0d, sum errors %0d",
                 num_rows, prod_errors, sum_errors);
    endtask

    // run length follows the row count, reset included
    initial begin
        wait (num_rows > 0);
        #((num_rows + 20) * CLK_PERIOD);
        $display("watchdog timeout, the pattern run did not finish in %0d cycles",
                 num_rows + 20);
        report_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        nrst        = 1'b0;
        en          = 1'b0;
        x           = '0;
        y           = '0;
        // idle mode matches the reset value of the stored modes
        mode        = MODE_NONE;
        prod_errors = 0;
        sum_errors  = 0;
        load_patterns();
        if (num_rows == 0) begin
            $display("no pattern rows to run, the test cannot pass");
            $display("Simulation failed");
        end else begin
            apply_reset();
            run_patterns();
            report_counts();
            if (prod_errors + sum_errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

//--- rtl/fusion_mac.sv
`timescale 1ns/1ps

module fusion_mac (
    input  logic                 clk,
    input  logic                 nrst,
    input  fusion_pkg::operand_t x,
    input  fusion_pkg::operand_t y,
    input  fusion_pkg::mode_t    mode,
    input  logic                 en,
    output fusion_pkg::product_t product,
    output fusion_pkg::sum_t     sum
);

    import fusion_pkg::*;

    product_t fused_prod;
    product_t stage_prod;
    mode_t    stage_mode;
    logic     stage_valid;

    // combinational multiplier
    fusion_array fusion_array_i (
        .x    (x),
        .y    (y),
        .mode (mode),
        .prod (fused_prod)
    );

    // pipeline register between multiplier and accumulator
    product_stage product_stage_i (
        .clk      (clk),
        .nrst     (nrst),
        .prod_in  (fused_prod),
        .mode_in  (mode),
        .valid_in (en),
        .prod     (stage_prod),
        .mode     (stage_mode),
        .valid    (stage_valid)
    );

    lane_accumulator lane_accumulator_i (
        .clk   (clk),
        .nrst  (nrst),
        .prod  (stage_prod),
        .mode  (stage_mode),
        .valid (stage_valid),
        .sum   (sum)
    );

    // registered product seen by the accumulator
    assign product = stage_prod;

endmodule

//--- rtl/lane_accumulator.sv
`timescale 1ns/1ps

module lane_accumulator (
    input  logic                 clk,
    input  logic                 nrst,
    input  fusion_pkg::product_t prod,
    input  fusion_pkg::mode_t    mode,
    input  logic                 valid,
    output fusion_pkg::sum_t     sum
);

    import fusion_pkg::*;

    // lane counts and base offsets of the packed lane groups
    localparam int N2_LANES  = PRODUCT_W / PROD2_W;
    localparam int N4_LANES  = 4;
    localparam int SUM4_LO   = SUM_W - N4_LANES * LANE4_W;
    localparam int PROD4_LO  = PRODUCT_W - N4_LANES * PROD4_W;
    localparam int SUM8_LO   = SUM_W - LANE8_W;
    localparam int PROD8_LO  = PRODUCT_W - PROD8_W;

    // mode of the item seen on the previous edge
    mode_t last_mode;
    // sum after adding the staged product, zero for invalid modes
    sum_t  next_sum;

    ////////////////////////////////////////
    // lane adders
    ////////////////////////////////////////

    always_comb begin
        logic [PROD2_W-1:0] p2;
        logic [PROD4_W-1:0] p4;
        logic [PROD8_W-1:0] p8;
        // bits outside the active lanes stay zero
        next_sum = '0;
        case (mode)
            MODE_2B: begin
                for (int i = 0; i < N2_LANES; i++) begin
                    p2 = prod[i*PROD2_W +: PROD2_W];
                    next_sum[i*LANE2_W +: LANE2_W] = sum[i*LANE2_W +: LANE2_W]
                        + {{(LANE2_W - PROD2_W){p2[PROD2_W-1]}}, p2};
                end
            end
            MODE_4B: begin
                for (int j = 0; j < N4_LANES; j++) begin
                    p4 = prod[PROD4_LO + j*PROD4_W +: PROD4_W];
                    next_sum[SUM4_LO + j*LANE4_W +: LANE4_W] =
                        sum[SUM4_LO + j*LANE4_W +: LANE4_W]
                        + {{(LANE4_W - PROD4_W){p4[PROD4_W-1]}}, p4};
                end
            end
            MODE_8B: begin
                p8 = prod[PROD8_LO +: PROD8_W];
                next_sum[SUM8_LO +: LANE8_W] = sum[SUM8_LO +: LANE8_W]
                    + {{(LANE8_W - PROD8_W){p8[PROD8_W-1]}}, p8};
            end
            default: next_sum = '0;
        endcase
    end

    ////////////////////////////////////////
    // clear and accumulate
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            last_mode <= MODE_NONE;
            sum       <= '0;
        end else begin
            last_mode <= mode;
            if (mode != last_mode) begin
                // first item of a new mode is dropped along with the old sum
                sum <= '0;
            end else if (valid) begin
                sum <= next_sum;
            end
        end
    end

endmodule

//--- rtl/product_stage.sv
`timescale 1ns/1ps

module product_stage (
    input  logic                 clk,
    input  logic                 nrst,
    input  fusion_pkg::product_t prod_in,
    input  fusion_pkg::mode_t    mode_in,
    input  logic                 valid_in,
    output fusion_pkg::product_t prod,
    output fusion_pkg::mode_t    mode,
    output logic                 valid
);

    import fusion_pkg::*;

    // one item sits here while the next one is multiplied
    // mode travels with the product so the accumulator sees a matched pair
    always_ff @(posedge clk) begin
        if (!nrst) begin
            prod  <= '0;
            mode  <= MODE_NONE;
            valid <= 1'b0;
        end else begin
            prod  <= prod_in;
            mode  <= mode_in;
            // en strobe, no back-pressure
            valid <= valid_in;
        end
    end

endmodule

//--- rtl/fusion_array.sv
`timescale 1ns/1ps

module fusion_array (
    input  fusion_pkg::operand_t x,
    input  fusion_pkg::operand_t y,
    input  fusion_pkg::mode_t    mode,
    output fusion_pkg::product_t prod
);

    import fusion_pkg::*;

    sign_flags_t             sx_flags;
    sign_flags_t             sy_flags;
    // per block results, blocks ordered hh hl lh ll
    block_prod_t             block_p [4];
    brick_prod_t [3:0]       brick_p [4];
    // fused 8x8 product
    logic [PROD8_W-1:0]      prod8;

    // widen a block product for the 8x8 merge
    function automatic logic [PROD8_W-1:0] ext_block(input block_prod_t v);
        return {{(PROD8_W - BLOCK_W){v[BLOCK_W-1]}}, v};
    endfunction

    sign_ctrl sign_ctrl_i (
        .mode (mode),
        .sx   (sx_flags),
        .sy   (sy_flags)
    );

    ////////////////////////////////////////
    // four 4x4 blocks on the nibble pairs
    ////////////////////////////////////////

    for (genvar b = 0; b < 4; b++) begin : g_block
        // blocks 0,1 use xh, blocks 0,2 use yh
        fusion_block fusion_block_i (
            .x       ((b < 2) ? x[7:4] : x[3:0]),
            .y       ((b % 2 == 0) ? y[7:4] : y[3:0]),
            .sx      (sx_flags[4*b +: 4]),
            .sy      (sy_flags[4*b +: 4]),
            .brick_p (brick_p[b]),
            .p       (block_p[b])
        );
    end

    // hh at 2^8, both cross blocks at 2^4, ll at 2^0
    assign prod8 = (ext_block(block_p[0]) << 8)
                 + ((ext_block(block_p[1]) + ext_block(block_p[2])) << 4)
                 + ext_block(block_p[3]);

    ////////////////////////////////////////
    // sum apart mapping onto the bus
    ////////////////////////////////////////

    always_comb begin
        prod = '0;
        case (mode)
            MODE_8B: begin
                prod[PRODUCT_W-PROD8_W +: PROD8_W] = prod8;
            end
            MODE_4B: begin
                // block b from the top, each signed 4x4 fits in 8 bits
                for (int b = 0; b < 4; b++) begin
                    prod[PRODUCT_W-(b+1)*PROD4_W +: PROD4_W] = block_p[b][PROD4_W-1:0];
                end
            end
            MODE_2B: begin
                // lane 4b+k from the top holds brick k of block b
                for (int i = 0; i < 16; i++) begin
                    prod[PRODUCT_W-(i+1)*PROD2_W +: PROD2_W] =
                        brick_p[i/4][i%4][PROD2_W-1:0];
                end
            end
            // invalid modes leave the bus at zero
            default: prod = '0;
        endcase
    end

endmodule

//--- rtl/fusion_block.sv
`timescale 1ns/1ps

module fusion_block (
    input  fusion_pkg::nibble_t           x,
    input  fusion_pkg::nibble_t           y,
    input  logic [3:0]                    sx,
    input  logic [3:0]                    sy,
    output fusion_pkg::brick_prod_t [3:0] brick_p,
    output fusion_pkg::block_prod_t       p
);

    import fusion_pkg::*;

    // brick products sign extended to the block width
    block_prod_t ext [4];

    ////////////////////////////////////////
    // four bitbricks, ordered hh hl lh ll
    ////////////////////////////////////////

    for (genvar k = 0; k < 4; k++) begin : g_brick
        // bricks 0,1 take the upper x crumb, bricks 0,2 the upper y crumb
        bitbrick bitbrick_i (
            .x  ((k < 2) ? x[3:2] : x[1:0]),
            .y  ((k % 2 == 0) ? y[3:2] : y[1:0]),
            .sx (sx[k]),
            .sy (sy[k]),
            .p  (brick_p[k])
        );
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            ext[k] = {{(BLOCK_W - BRICK_W){brick_p[k][BRICK_W-1]}}, brick_p[k]};
        end
    end

    // shift-add merge, hh weighs 2^4, the cross terms 2^2
    // exact in 9 bits even for an unsigned x unsigned block
    assign p = (ext[0] << 4) + (ext[1] << 2) + (ext[2] << 2) + ext[3];

endmodule

//--- rtl/sign_ctrl.sv
`timescale 1ns/1ps

module sign_ctrl (
    input  fusion_pkg::mode_t       mode,
    output fusion_pkg::sign_flags_t sx,
    output fusion_pkg::sign_flags_t sy
);

    import fusion_pkg::*;

    // crumb index c counts from the operand lsb, crumb 3 is bits 7:6
    // true when crumb c carries the top bit of its lane in mode m
    function automatic logic is_top_crumb(input logic [1:0] c, input mode_t m);
        case (m)
            // every crumb is its own lane
            MODE_2B: return 1'b1;
            // crumbs 3 and 1 top each nibble
            MODE_4B: return c[0];
            // 8-bit rule, also used for invalid modes
            default: return (c == 2'd3);
        endcase
    endfunction

    always_comb begin
        logic [1:0] xc;
        logic [1:0] yc;
        sx = '0;
        sy = '0;
        for (int b = 0; b < 4; b++) begin
            for (int k = 0; k < 4; k++) begin
                // x nibble is high for blocks hh and hl
                // x crumb is upper for bricks hh and hl
                xc = {b < 2, k < 2};
                // y nibble is high for blocks hh and lh, same for the y crumb
                yc = {(b % 2) == 0, (k % 2) == 0};
                sx[4*b+k] = is_top_crumb(xc, mode);
                sy[4*b+k] = is_top_crumb(yc, mode);
            end
        end
    end

endmodule

//--- rtl/bitbrick.sv
`timescale 1ns/1ps

module bitbrick (
    input  fusion_pkg::crumb_t      x,
    input  fusion_pkg::crumb_t      y,
    input  logic                    sx,
    input  logic                    sy,
    output fusion_pkg::brick_prod_t p
);

    // 3-bit operands, sign extended when flagged, zero extended otherwise
    logic [2:0] xi;
    logic [2:0] yi;
    // baugh-wooley partial product rows
    logic [2:0] pp0;
    logic [2:0] pp1;
    logic [2:0] pp2;
    // column sums and carries of the reduction tree
    logic       c1;
    logic       s2a, c2a, c2b;
    logic       s3a, c3a, c3b;

    assign xi = {sx & x[1], x};
    assign yi = {sy & y[1], y};

    // rows 0 and 1 invert the term holding the x sign bit
    assign pp0 = {~(xi[2] & yi[0]), xi[1] & yi[0], xi[0] & yi[0]};
    assign pp1 = {~(xi[2] & yi[1]), xi[1] & yi[1], xi[0] & yi[1]};
    // row 2 is weighted by the y sign bit, so its low terms are inverted
    assign pp2 = {xi[2] & yi[2], ~(xi[1] & yi[2]), ~(xi[0] & yi[2])};

    // column 0
    assign p[0] = pp0[0];

    // column 1, half adder
    assign p[1] = pp0[1] ^ pp1[0];
    assign c1   = pp0[1] & pp1[0];

    // column 2, full adder then half adder with the column 1 carry
    assign s2a  = pp0[2] ^ pp1[1] ^ pp2[0];
    assign c2a  = (pp0[2] & pp1[1]) | (pp1[1] & pp2[0]) | (pp2[0] & pp0[2]);
    assign p[2] = s2a ^ c1;
    assign c2b  = s2a & c1;

    // column 3 takes the correction one of the baugh-wooley form
    assign s3a  = pp1[2] ^ pp2[1] ^ c2a;
    assign c3a  = (pp1[2] & pp2[1]) | (pp2[1] & c2a) | (c2a & pp1[2]);
    assign p[3] = ~(s3a ^ c2b);
    assign c3b  = s3a | c2b;

    // column 4, carry out of the top is dropped
    // result fits 5 bits signed, so the truncation is exact
    assign p[4] = pp2[2] ^ c3a ^ c3b;

endmodule

//--- rtl/fusion_pkg.sv
package fusion_pkg;

    ////////////////////////////////////////
    // precision modes
    ////////////////////////////////////////

    // any encoding not listed is an invalid mode
    // MODE_NONE only appears as the reset value of stored modes
    typedef enum logic [3:0] {
        MODE_2B   = 4'd0,
        MODE_4B   = 4'd1,
        MODE_8B   = 4'd2,
        MODE_NONE = 4'd15
    } mode_t;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    localparam int OPERAND_W  = 8;
    localparam int NIBBLE_W   = 4;
    localparam int CRUMB_W    = 2;
    // 3x3 product of extended crumbs
    localparam int BRICK_W    = 5;
    // 4x4 block product, wide enough for unsigned x unsigned
    localparam int BLOCK_W    = 9;
    localparam int NUM_BRICKS = 16;
    localparam int PRODUCT_W  = 64;
    localparam int SUM_W      = 128;

    // product lane width per mode
    localparam int PROD2_W = 4;
    localparam int PROD4_W = 8;
    localparam int PROD8_W = 16;
    // accumulator lane width per mode, four guard bits over the product
    localparam int LANE2_W = 8;
    localparam int LANE4_W = 12;
    localparam int LANE8_W = 20;

    typedef logic [OPERAND_W-1:0]       operand_t;
    typedef logic [NIBBLE_W-1:0]        nibble_t;
    typedef logic [CRUMB_W-1:0]         crumb_t;
    typedef logic signed [BRICK_W-1:0]  brick_prod_t;
    typedef logic signed [BLOCK_W-1:0]  block_prod_t;
    typedef logic [PRODUCT_W-1:0]       product_t;
    typedef logic [SUM_W-1:0]           sum_t;
    // bit 4*block + brick, blocks and bricks both ordered hh, hl, lh, ll
    typedef logic [NUM_BRICKS-1:0]      sign_flags_t;

endpackage
